//--- hdl/vcr_pkg.sv
// router widths, index and vector typedefs, flit, credit and APB structs, register offsets
package vcr_pkg;

   // ----------------------------------------------------------
   // router dimensions
   // ----------------------------------------------------------
   localparam int num_ports = 4;
   localparam int num_vcs = 2;
   localparam int flit_data_width = 16;

   typedef logic [$clog2(num_ports)-1:0] port_idx_t;
   typedef logic [$clog2(num_vcs)-1:0] vc_idx_t;
   typedef logic [num_ports-1:0] port_vec_t;
   typedef logic [num_vcs-1:0] vc_vec_t;
   typedef logic [flit_data_width-1:0] flit_data_t;

   // dest is the lookahead output port of this router
   typedef struct packed {
      logic valid;
      logic head;
      logic tail;
      vc_idx_t vc;
      port_idx_t dest;
      flit_data_t data;
   } flit_t;

   typedef struct packed {
      logic valid;
      vc_idx_t vc;
   } credit_t;

   // ----------------------------------------------------------
   // register interface
   // ----------------------------------------------------------
   typedef logic [7:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic psel;
      logic penable;
      logic pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic pready;
      logic pslverr;
   } apb_rsp_t;

   // [3:0] input buffer overflow, [7:4] output credit overflow
   typedef logic [2*num_ports-1:0] err_vec_t;

   localparam apb_addr_t reg_ctrl_addr = 8'h00;
   localparam apb_addr_t reg_err_status_addr = 8'h04;

endpackage

//--- hdl/vcr_input_port.sv
// input port with one circular flit FIFO per VC, overflow detection and credit return
`timescale 1ns/10ps

module vcr_input_port #(
   parameter int buffer_depth = 4
) (
   input  logic clk,
   input  logic rst,
   input  vcr_pkg::flit_t channel_in,
   input  vcr_pkg::vc_vec_t pop,
   output vcr_pkg::flit_t head_flits [vcr_pkg::num_vcs],
   output vcr_pkg::credit_t flow_ctrl_out,
   output logic overflow
);

   localparam int ptr_width = $clog2(buffer_depth);
   localparam int cnt_width = $clog2(buffer_depth + 1);

   vcr_pkg::flit_t mem [vcr_pkg::num_vcs][buffer_depth];
   logic [ptr_width-1:0] rd_ptr [vcr_pkg::num_vcs];
   logic [ptr_width-1:0] wr_ptr [vcr_pkg::num_vcs];
   logic [cnt_width-1:0] count [vcr_pkg::num_vcs];

   vcr_pkg::vc_vec_t full;
   vcr_pkg::vc_vec_t push;
   vcr_pkg::vc_idx_t pop_vc;

   always_comb
   begin
      pop_vc = '0;
      for (int v = 0; v < vcr_pkg::num_vcs; v++)
      begin
         full[v] = (count[v] == cnt_width'(buffer_depth));
         push[v] = channel_in.valid && (channel_in.vc == vcr_pkg::vc_idx_t'(v)) && !full[v];
         if (pop[v])
            pop_vc = vcr_pkg::vc_idx_t'(v);
         // oldest entry, valid only while the FIFO holds something
         head_flits[v] = mem[v][rd_ptr[v]];
         head_flits[v].valid = (count[v] != '0);
      end
      // a flit sent without credit finds its FIFO full and is lost
      overflow = channel_in.valid && full[channel_in.vc];
   end

   always_ff @(posedge clk)
   begin
      for (int v = 0; v < vcr_pkg::num_vcs; v++)
      begin
         if (push[v])
            mem[v][wr_ptr[v]] <= channel_in;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
         begin
            rd_ptr[v] <= '0;
            wr_ptr[v] <= '0;
            count[v] <= '0;
         end
         flow_ctrl_out <= '0;
      end
      else
      begin
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
         begin
            if (push[v])
               wr_ptr[v] <= (wr_ptr[v] == ptr_width'(buffer_depth - 1)) ? '0 : wr_ptr[v] + 1'b1;
            if (pop[v])
               rd_ptr[v] <= (rd_ptr[v] == ptr_width'(buffer_depth - 1)) ? '0 : rd_ptr[v] + 1'b1;
            case ({push[v], pop[v]})
               2'b10: count[v] <= count[v] + 1'b1;
               2'b01: count[v] <= count[v] - 1'b1;
               default: count[v] <= count[v];
            endcase
         end
         // one credit per flit leaving, at the grant edge
         flow_ctrl_out.valid <= |pop;
         flow_ctrl_out.vc <= pop_vc;
      end
   end

endmodule

//--- hdl/vcr_sw_alloc.sv
// separable input-first switch allocator with round-robin arbiters and output VC ownership
`timescale 1ns/10ps

module vcr_sw_alloc (
   input  logic clk,
   input  logic rst,
   input  vcr_pkg::flit_t head_flits [vcr_pkg::num_ports][vcr_pkg::num_vcs],
   input  vcr_pkg::vc_vec_t credit_avail [vcr_pkg::num_ports],
   output vcr_pkg::vc_vec_t pop [vcr_pkg::num_ports],
   output vcr_pkg::port_vec_t grant [vcr_pkg::num_ports],
   output vcr_pkg::vc_idx_t send_vc [vcr_pkg::num_ports],
   output vcr_pkg::port_vec_t send
);

   // output VC lock, held from head to tail
   logic owned [vcr_pkg::num_ports][vcr_pkg::num_vcs];
   vcr_pkg::port_idx_t owner [vcr_pkg::num_ports][vcr_pkg::num_vcs];

   vcr_pkg::vc_idx_t in_ptr [vcr_pkg::num_ports];
   vcr_pkg::port_idx_t out_ptr [vcr_pkg::num_ports];

   vcr_pkg::vc_vec_t elig [vcr_pkg::num_ports];
   vcr_pkg::port_vec_t req;
   vcr_pkg::vc_idx_t req_vc [vcr_pkg::num_ports];
   vcr_pkg::flit_t req_flit [vcr_pkg::num_ports];
   vcr_pkg::port_idx_t win [vcr_pkg::num_ports];

   // ----------------------------------------------------------
   // eligibility and input stage
   // ----------------------------------------------------------
   always_comb
   begin
      vcr_pkg::flit_t f;
      int vv;
      logic found;
      for (int i = 0; i < vcr_pkg::num_ports; i++)
      begin
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
         begin
            f = head_flits[i][v];
            elig[i][v] = f.valid && credit_avail[f.dest][f.vc] &&
                         ((f.head && !owned[f.dest][f.vc]) ||
                          (owned[f.dest][f.vc] && owner[f.dest][f.vc] == vcr_pkg::port_idx_t'(i)));
         end
         // round-robin over this input's eligible VCs
         req[i] = 1'b0;
         req_vc[i] = in_ptr[i];
         found = 1'b0;
         for (int k = 0; k < vcr_pkg::num_vcs; k++)
         begin
            vv = (int'(in_ptr[i]) + k) % vcr_pkg::num_vcs;
            if (!found && elig[i][vv])
            begin
               found = 1'b1;
               req[i] = 1'b1;
               req_vc[i] = vcr_pkg::vc_idx_t'(vv);
            end
         end
         req_flit[i] = head_flits[i][req_vc[i]];
      end
   end

   // ----------------------------------------------------------
   // output stage
   // ----------------------------------------------------------
   always_comb
   begin
      int ii;
      logic found;
      for (int o = 0; o < vcr_pkg::num_ports; o++)
      begin
         grant[o] = '0;
         win[o] = out_ptr[o];
         found = 1'b0;
         for (int k = 0; k < vcr_pkg::num_ports; k++)
         begin
            ii = (int'(out_ptr[o]) + k) % vcr_pkg::num_ports;
            if (!found && req[ii] && req_flit[ii].dest == vcr_pkg::port_idx_t'(o))
            begin
               found = 1'b1;
               grant[o][ii] = 1'b1;
               win[o] = vcr_pkg::port_idx_t'(ii);
            end
         end
         send[o] = found;
         send_vc[o] = req_flit[win[o]].vc;
      end
   end

   always_comb
   begin
      for (int i = 0; i < vcr_pkg::num_ports; i++)
      begin
         pop[i] = '0;
         if (req[i] && grant[req_flit[i].dest][i])
            pop[i][req_vc[i]] = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int o = 0; o < vcr_pkg::num_ports; o++)
         begin
            for (int v = 0; v < vcr_pkg::num_vcs; v++)
            begin
               owned[o][v] <= 1'b0;
               owner[o][v] <= '0;
            end
            in_ptr[o] <= '0;
            out_ptr[o] <= '0;
         end
      end
      else
      begin
         for (int i = 0; i < vcr_pkg::num_ports; i++)
         begin
            if (pop[i] != '0)
               in_ptr[i] <= vcr_pkg::vc_idx_t'((int'(req_vc[i]) + 1) % vcr_pkg::num_vcs);
         end
         for (int o = 0; o < vcr_pkg::num_ports; o++)
         begin
            if (send[o])
            begin
               out_ptr[o] <= vcr_pkg::port_idx_t'((int'(win[o]) + 1) % vcr_pkg::num_ports);
               // tail releases, a lone head-tail flit never locks
               if (req_flit[win[o]].tail)
                  owned[o][send_vc[o]] <= 1'b0;
               else if (req_flit[win[o]].head)
               begin
                  owned[o][send_vc[o]] <= 1'b1;
                  owner[o][send_vc[o]] <= win[o];
               end
            end
         end
      end
   end

endmodule

//--- hdl/vcr_output_port.sv
// output port with crossbar column mux, output flit register and per-VC credit counters
`timescale 1ns/10ps

module vcr_output_port #(
   parameter int buffer_depth = 4
) (
   input  logic clk,
   input  logic rst,
   input  vcr_pkg::flit_t flits_in [vcr_pkg::num_ports],
   input  vcr_pkg::port_vec_t grant,
   input  logic send,
   input  vcr_pkg::vc_idx_t send_vc,
   input  vcr_pkg::credit_t flow_ctrl_in,
   output vcr_pkg::flit_t channel_out,
   output vcr_pkg::vc_vec_t credit_avail,
   output logic credit_overflow
);

   localparam int cnt_width = $clog2(buffer_depth + 1);

   logic [cnt_width-1:0] cnt [vcr_pkg::num_vcs];
   vcr_pkg::vc_vec_t inc;
   vcr_pkg::vc_vec_t dec;
   vcr_pkg::vc_vec_t at_max;
   vcr_pkg::flit_t sel_flit;
   vcr_pkg::flit_t out_q;
   logic out_valid;

   // crossbar column, grant is one-hot
   always_comb
   begin
      sel_flit = flits_in[0];
      for (int ii = 0; ii < vcr_pkg::num_ports; ii++)
      begin
         if (grant[ii])
            sel_flit = flits_in[ii];
      end
   end

   always_comb
   begin
      for (int v = 0; v < vcr_pkg::num_vcs; v++)
      begin
         dec[v] = send && (send_vc == vcr_pkg::vc_idx_t'(v));
         inc[v] = flow_ctrl_in.valid && (flow_ctrl_in.vc == vcr_pkg::vc_idx_t'(v));
         at_max[v] = (cnt[v] == cnt_width'(buffer_depth));
         credit_avail[v] = (cnt[v] != '0);
      end
      // a credit beyond the downstream buffer size cannot be real
      credit_overflow = |(inc & at_max);
      channel_out = out_q;
      channel_out.valid = out_valid;
   end

   always_ff @(posedge clk)
   begin
      if (send)
         out_q <= sel_flit;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
            cnt[v] <= cnt_width'(buffer_depth);
      end
      else
      begin
         out_valid <= send;
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
         begin
            case ({inc[v] && !at_max[v], dec[v]})
               2'b10: cnt[v] <= cnt[v] + 1'b1;
               2'b01: cnt[v] <= cnt[v] - 1'b1;
               default: cnt[v] <= cnt[v];
            endcase
         end
      end
   end

endmodule

//--- hdl/vcr_err_cfg.sv
// APB register block with capture mode control, sticky error status and error output
`timescale 1ns/10ps

module vcr_err_cfg (
   input  logic clk,
   input  logic rst,
   input  vcr_pkg::apb_req_t apb_req,
   output vcr_pkg::apb_rsp_t apb_rsp,
   input  vcr_pkg::err_vec_t errors,
   output logic error
);

   logic hold_mode;
   vcr_pkg::err_vec_t err_status;
   vcr_pkg::err_vec_t errors_q;
   vcr_pkg::err_vec_t clr;
   logic access;
   logic ctrl_hit;
   logic status_hit;
   logic wr_en;

   // ----------------------------------------------------------
   // APB decode, zero wait states
   // ----------------------------------------------------------
   always_comb
   begin
      access = apb_req.psel && apb_req.penable;
      ctrl_hit = (apb_req.paddr == vcr_pkg::reg_ctrl_addr);
      status_hit = (apb_req.paddr == vcr_pkg::reg_err_status_addr);
      wr_en = access && apb_req.pwrite;
      clr = (wr_en && status_hit) ? vcr_pkg::err_vec_t'(apb_req.pwdata) : '0;

      apb_rsp.pready = access;
      apb_rsp.pslverr = access && !(ctrl_hit || status_hit);
      apb_rsp.prdata = '0;
      if (ctrl_hit)
         apb_rsp.prdata[0] = hold_mode;
      else if (status_hit)
         apb_rsp.prdata[$bits(vcr_pkg::err_vec_t)-1:0] = err_status;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         hold_mode <= 1'b0;
         err_status <= '0;
         errors_q <= '0;
      end
      else
      begin
         errors_q <= errors;
         if (wr_en && ctrl_hit)
            hold_mode <= apb_req.pwdata[0];
         // write-1 clear, a new error in the same cycle stays set
         err_status <= (err_status & ~clr) | errors;
      end
   end

   // hold mode keeps error up until software clears the status
   assign error = hold_mode ? |err_status : |errors_q;

endmodule

//--- hdl/vcr_top.sv
// top level of the four-port two-VC router with ports, switch allocator and register block
`timescale 1ns/10ps

module vcr_top #(
   parameter int buffer_depth = 4
) (
   input  logic clk,
   input  logic rst,
   input  vcr_pkg::flit_t channel_in_ip [vcr_pkg::num_ports],
   output vcr_pkg::flit_t channel_out_op [vcr_pkg::num_ports],
   output vcr_pkg::credit_t flow_ctrl_out_ip [vcr_pkg::num_ports],
   input  vcr_pkg::credit_t flow_ctrl_in_op [vcr_pkg::num_ports],
   input  vcr_pkg::apb_req_t apb_req,
   output vcr_pkg::apb_rsp_t apb_rsp,
   output logic error
);

   vcr_pkg::flit_t head_flits_ip [vcr_pkg::num_ports][vcr_pkg::num_vcs];
   vcr_pkg::flit_t xbr_flits_ip [vcr_pkg::num_ports];
   vcr_pkg::vc_vec_t pop_ip [vcr_pkg::num_ports];
   vcr_pkg::vc_vec_t credit_avail_op [vcr_pkg::num_ports];
   vcr_pkg::port_vec_t grant_op [vcr_pkg::num_ports];
   vcr_pkg::vc_idx_t send_vc_op [vcr_pkg::num_ports];
   vcr_pkg::port_vec_t send_op;
   vcr_pkg::port_vec_t overflow_ip;
   vcr_pkg::port_vec_t credit_overflow_op;
   vcr_pkg::err_vec_t err_vec;

   // ----------------------------------------------------------
   // input ports
   // ----------------------------------------------------------
   for (genvar ip = 0; ip < vcr_pkg::num_ports; ip++)
   begin : ips
      vcr_input_port #(.buffer_depth(buffer_depth)) ipc (
         .clk(clk),
         .rst(rst),
         .channel_in(channel_in_ip[ip]),
         .pop(pop_ip[ip]),
         .head_flits(head_flits_ip[ip]),
         .flow_ctrl_out(flow_ctrl_out_ip[ip]),
         .overflow(overflow_ip[ip])
      );
   end

   // popped head of each input feeds the crossbar
   always_comb
   begin
      for (int ip = 0; ip < vcr_pkg::num_ports; ip++)
      begin
         xbr_flits_ip[ip] = head_flits_ip[ip][0];
         for (int v = 0; v < vcr_pkg::num_vcs; v++)
         begin
            if (pop_ip[ip][v])
               xbr_flits_ip[ip] = head_flits_ip[ip][v];
         end
      end
   end

   vcr_sw_alloc alo (
      .clk(clk),
      .rst(rst),
      .head_flits(head_flits_ip),
      .credit_avail(credit_avail_op),
      .pop(pop_ip),
      .grant(grant_op),
      .send_vc(send_vc_op),
      .send(send_op)
   );

   // ----------------------------------------------------------
   // output ports
   // ----------------------------------------------------------
   for (genvar op = 0; op < vcr_pkg::num_ports; op++)
   begin : ops
      vcr_output_port #(.buffer_depth(buffer_depth)) opc (
         .clk(clk),
         .rst(rst),
         .flits_in(xbr_flits_ip),
         .grant(grant_op[op]),
         .send(send_op[op]),
         .send_vc(send_vc_op[op]),
         .flow_ctrl_in(flow_ctrl_in_op[op]),
         .channel_out(channel_out_op[op]),
         .credit_avail(credit_avail_op[op]),
         .credit_overflow(credit_overflow_op[op])
      );
   end

   // credit overflow in the upper half, buffer overflow in the lower
   assign err_vec = {credit_overflow_op, overflow_ip};

   vcr_err_cfg chk (
      .clk(clk),
      .rst(rst),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .errors(err_vec),
      .error(error)
   );

endmodule

//--- bench/vcr_tb_table.svh
// packet table entry type and packet table with credit-hold windows and expected error bits
`ifndef vcr_tb_table_svh
`define vcr_tb_table_svh

// an entry with last set closes a group of packets that run together
typedef struct packed {
   vcr_pkg::port_idx_t src;
   vcr_pkg::vc_idx_t vc;
   vcr_pkg::port_idx_t dest;
   logic [7:0] len;
   vcr_pkg::flit_data_t base;
   vcr_pkg::port_vec_t hold;
   vcr_pkg::err_vec_t exp_err;
   logic chk_lat;
   logic last;
} pkt_entry_t;

localparam int num_entries = 14;

// src, vc, dest, len, base data, hold mask, expected errors, latency check, last
localparam pkt_entry_t pkt_table [num_entries] = '{
   '{2'd0, 1'b0, 2'd2, 8'd1, 16'h1000, 4'b0000, 8'h00, 1'b1, 1'b1},
   '{2'd1, 1'b1, 2'd3, 8'd1, 16'h1100, 4'b0000, 8'h00, 1'b1, 1'b1},
   '{2'd0, 1'b0, 2'd1, 8'd5, 16'h2000, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd2, 1'b0, 2'd1, 8'd6, 16'h2100, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd3, 1'b1, 2'd1, 8'd4, 16'h2200, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd1, 1'b0, 2'd0, 8'd3, 16'h2300, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd0, 1'b1, 2'd3, 8'd4, 16'h2400, 4'b0000, 8'h00, 1'b0, 1'b1},
   '{2'd1, 1'b0, 2'd0, 8'd6, 16'h3000, 4'b0001, 8'h00, 1'b0, 1'b0},
   '{2'd2, 1'b1, 2'd0, 8'd10, 16'h3100, 4'b0001, 8'h00, 1'b0, 1'b1},
   '{2'd3, 1'b0, 2'd2, 8'd10, 16'h4000, 4'b0100, 8'h08, 1'b0, 1'b1},
   '{2'd0, 1'b1, 2'd1, 8'd2, 16'h5000, 4'b0000, 8'h20, 1'b0, 1'b1},
   '{2'd1, 1'b1, 2'd2, 8'd3, 16'h6000, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd2, 1'b0, 2'd3, 8'd5, 16'h6100, 4'b0000, 8'h00, 1'b0, 1'b0},
   '{2'd3, 1'b1, 2'd2, 8'd2, 16'h6200, 4'b0000, 8'h00, 1'b0, 1'b1}
};

`endif

//--- bench/vcr_tb.sv
// router testbench with clock, reset, table loop, upstream and downstream models, scoreboard
`timescale 1ns/10ps

module vcr_tb;

   `include "vcr_tb_table.svh"

   localparam int buffer_depth = 4;
   localparam int np = vcr_pkg::num_ports;
   localparam int nv = vcr_pkg::num_vcs;

   logic clk;
   logic rst;
   vcr_pkg::flit_t channel_in_ip [np];
   vcr_pkg::flit_t channel_out_op [np];
   vcr_pkg::credit_t flow_ctrl_out_ip [np];
   vcr_pkg::credit_t flow_ctrl_in_op [np];
   vcr_pkg::apb_req_t apb_req;
   vcr_pkg::apb_rsp_t apb_rsp;
   logic error;

   // upstream credits and downstream credits owed per port and VC
   int ucred [np][nv];
   int pending [np][nv];
   int held_recv [np][nv];
   int lock_src [np][nv];
   logic busy [np][nv];
   vcr_pkg::flit_t exq [np][nv][$];
   int excyc [np][nv][$];
   pkt_entry_t pq [np][$];
   int gap_q [np][$];
   logic sending [np];
   vcr_pkg::port_vec_t hold_mask;
   logic spur_go;
   vcr_pkg::port_idx_t spur_op;
   vcr_pkg::vc_idx_t spur_vc;
   int cyc;

   vcr_top #(.buffer_depth(buffer_depth)) uut (
      .clk(clk),
      .rst(rst),
      .channel_in_ip(channel_in_ip),
      .channel_out_op(channel_out_op),
      .flow_ctrl_out_ip(flow_ctrl_out_ip),
      .flow_ctrl_in_op(flow_ctrl_in_op),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .error(error)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk)
      cyc = cyc + 1;

   // ----------------------------------------------------------
   // helpers
   // ----------------------------------------------------------
   task stop_run();
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic fail_msg(input string msg);
      $display("%s at %0t", msg, $time);
      stop_run();
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp)
      else
      begin
         $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
         stop_run();
      end
   endtask

   // inputs change 2 ns after the rising edge
   task tick();
      @(posedge clk);
      #2;
   endtask

   task automatic apb_access(input logic wr, input vcr_pkg::apb_addr_t addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic slverr);
      apb_req.psel = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite = wr;
      apb_req.paddr = addr;
      apb_req.pwdata = wdata;
      tick();
      apb_req.penable = 1'b1;
      @(negedge clk);
      check_val("apb_rsp.pready", 1, apb_rsp.pready);
      rdata = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      tick();
      apb_req = '0;
   endtask

   task automatic apb_read_check(input vcr_pkg::apb_addr_t addr, input logic [31:0] exp,
                                 input logic exp_err);
      logic [31:0] rd;
      logic se;
      apb_access(1'b0, addr, 32'h0, rd, se);
      check_val("apb_rsp.pslverr", exp_err, se);
      if (!exp_err)
         check_val("apb_rsp.prdata", exp, rd);
   endtask

   task automatic apb_write(input vcr_pkg::apb_addr_t addr, input logic [31:0] data);
      logic [31:0] rd;
      logic se;
      apb_access(1'b1, addr, data, rd, se);
      check_val("apb_rsp.pslverr", 0, se);
   endtask

   function automatic logic traffic_idle();
      logic idle;
      idle = 1'b1;
      for (int i = 0; i < np; i++)
      begin
         if (pq[i].size() != 0 || sending[i])
            idle = 1'b0;
         for (int v = 0; v < nv; v++)
         begin
            if (exq[i][v].size() != 0 || pending[i][v] != 0)
               idle = 1'b0;
         end
      end
      return idle;
   endfunction

   // ----------------------------------------------------------
   // upstream senders for each input port
   // ----------------------------------------------------------
   task automatic send_packet(input int i, input pkt_entry_t e);
      vcr_pkg::flit_t f;
      int t;
      for (int k = 0; k < int'(e.len); k++)
      begin
         f = '0;
         f.valid = 1'b1;
         f.head = (k == 0);
         f.tail = (k == int'(e.len) - 1);
         f.vc = e.vc;
         f.dest = e.dest;
         f.data = e.base + vcr_pkg::flit_data_t'(k);
         t = 0;
         while (ucred[i][e.vc] == 0)
         begin
            tick();
            t++;
            if (t > 2000)
               fail_msg($sformatf("no credit returned to input %0d", i));
         end
         exq[i][e.vc].push_back(f);
         excyc[i][e.vc].push_back(e.chk_lat ? cyc : -1);
         channel_in_ip[i] = f;
         ucred[i][e.vc]--;
         tick();
         channel_in_ip[i] = '0;
      end
   endtask

   for (genvar g = 0; g < np; g++)
   begin : senders
      initial
      begin : run
         pkt_entry_t e;
         int gap;
         forever
         begin
            if (pq[g].size() > 0)
            begin
               sending[g] = 1'b1;
               e = pq[g].pop_front();
               gap = gap_q[g].pop_front();
               send_packet(g, e);
               repeat (gap) tick();
               sending[g] = 1'b0;
            end
            else
               tick();
         end
      end
   end

   // downstream returns one credit per cycle and output while not held
   initial
   begin : downstream_model
      logic done;
      forever
      begin
         tick();
         for (int o = 0; o < np; o++)
         begin
            flow_ctrl_in_op[o] = '0;
            done = 1'b0;
            if (spur_go && spur_op == vcr_pkg::port_idx_t'(o))
            begin
               flow_ctrl_in_op[o].valid = 1'b1;
               flow_ctrl_in_op[o].vc = spur_vc;
               spur_go = 1'b0;
               done = 1'b1;
            end
            for (int v = 0; v < nv; v++)
            begin
               if (!done && !hold_mask[o] && pending[o][v] > 0)
               begin
                  flow_ctrl_in_op[o].valid = 1'b1;
                  flow_ctrl_in_op[o].vc = vcr_pkg::vc_idx_t'(v);
                  pending[o][v]--;
                  done = 1'b1;
               end
            end
         end
      end
   end

   // ----------------------------------------------------------
   // monitor and scoreboard sampled on the falling edge
   // ----------------------------------------------------------
   always @(negedge clk)
   begin : monitor
      vcr_pkg::flit_t f;
      int s;
      int v;
      if (!rst)
      begin
         for (int i = 0; i < np; i++)
         begin
            if (flow_ctrl_out_ip[i].valid)
            begin
               ucred[i][flow_ctrl_out_ip[i].vc]++;
               if (ucred[i][flow_ctrl_out_ip[i].vc] > buffer_depth)
                  fail_msg($sformatf("unexpected credit on flow_ctrl_out_ip[%0d]", i));
            end
         end
         for (int o = 0; o < np; o++)
         begin
            f = channel_out_op[o];
            if (f.valid)
            begin
               v = int'(f.vc);
               s = -1;
               check_val($sformatf("channel_out_op[%0d].dest", o), o, f.dest);
               if (f.head)
               begin
                  check_val($sformatf("busy[%0d][%0d]", o, v), 0, busy[o][v]);
                  for (int i = 0; i < np; i++)
                  begin
                     if (s < 0 && exq[i][v].size() > 0 && exq[i][v][0] === f)
                        s = i;
                  end
                  if (s < 0)
                     fail_msg($sformatf("unexpected head flit on output %0d", o));
                  lock_src[o][v] = s;
               end
               else
               begin
                  check_val($sformatf("busy[%0d][%0d]", o, v), 1, busy[o][v]);
                  s = lock_src[o][v];
               end
               if (exq[s][v].size() == 0)
                  fail_msg($sformatf("flit on output %0d with nothing expected", o));
               check_val($sformatf("channel_out_op[%0d]", o), exq[s][v][0], f);
               if (excyc[s][v][0] >= 0)
               begin
                  check_val("latency", 2, cyc - excyc[s][v][0]);
                  check_val("flow_ctrl_out_ip.valid", 1, flow_ctrl_out_ip[s].valid);
                  check_val("flow_ctrl_out_ip.vc", v, flow_ctrl_out_ip[s].vc);
               end
               void'(exq[s][v].pop_front());
               void'(excyc[s][v].pop_front());
               busy[o][v] = !f.tail;
               pending[o][v]++;
               if (hold_mask[o])
                  held_recv[o][v]++;
            end
         end
      end
   end

   // ----------------------------------------------------------
   // error scenarios
   // ----------------------------------------------------------
   task automatic inject_flit(input pkt_entry_t e);
      channel_in_ip[e.src] = '0;
      channel_in_ip[e.src].valid = 1'b1;
      channel_in_ip[e.src].vc = e.vc;
      channel_in_ip[e.src].dest = e.dest;
      channel_in_ip[e.src].data = 16'hbad0;
      tick();
      channel_in_ip[e.src] = '0;
   endtask

   task automatic buffer_overflow(input pkt_entry_t e);
      check_val("ucred", 0, ucred[e.src][e.vc]);
      // error pulses once in no-hold mode
      inject_flit(e);
      check_val("error", 1, error);
      tick();
      check_val("error", 0, error);
      apb_read_check(vcr_pkg::reg_err_status_addr, e.exp_err, 1'b0);
      apb_write(vcr_pkg::reg_err_status_addr, e.exp_err);
      apb_read_check(vcr_pkg::reg_err_status_addr, 0, 1'b0);
      // in hold mode error stays until cleared
      apb_write(vcr_pkg::reg_ctrl_addr, 1);
      apb_read_check(vcr_pkg::reg_ctrl_addr, 1, 1'b0);
      inject_flit(e);
      repeat (4)
      begin
         check_val("error", 1, error);
         tick();
      end
      apb_read_check(vcr_pkg::reg_err_status_addr, e.exp_err, 1'b0);
      apb_write(vcr_pkg::reg_err_status_addr, e.exp_err);
      check_val("error", 0, error);
      apb_write(vcr_pkg::reg_ctrl_addr, 0);
   endtask

   task automatic credit_overflow(input pkt_entry_t e);
      int t;
      @(negedge clk);
      spur_op = e.dest;
      spur_vc = e.vc;
      spur_go = 1'b1;
      t = 0;
      while (spur_go)
      begin
         tick();
         t++;
         if (t > 20)
            fail_msg("spurious credit was never driven");
      end
      tick();
      apb_read_check(vcr_pkg::reg_err_status_addr, e.exp_err, 1'b0);
      apb_write(vcr_pkg::reg_err_status_addr, e.exp_err);
      apb_read_check(vcr_pkg::reg_err_status_addr, 0, 1'b0);
   endtask

   task automatic run_group(input pkt_entry_t e);
      int t;
      if (hold_mask != '0)
      begin
         repeat (40) tick();
         for (int o = 0; o < np; o++)
         begin
            for (int v = 0; v < nv; v++)
            begin
               assert (held_recv[o][v] <= buffer_depth)
               else
               begin
                  $display("ERR %0t held_recv[%0d][%0d] exp <= %0d got %0d",
                           $time, o, v, buffer_depth, held_recv[o][v]);
                  stop_run();
               end
            end
         end
         if (e.exp_err[np-1:0] != '0)
            buffer_overflow(e);
         @(negedge clk);
         hold_mask = '0;
      end
      t = 0;
      while (!traffic_idle())
      begin
         tick();
         t++;
         if (t > 3000)
            fail_msg("traffic did not drain");
      end
      if (e.exp_err[2*np-1:np] != '0)
         credit_overflow(e);
      for (int o = 0; o < np; o++)
      begin
         for (int v = 0; v < nv; v++)
         begin
            held_recv[o][v] = 0;
            check_val($sformatf("ucred[%0d][%0d]", o, v), buffer_depth, ucred[o][v]);
         end
      end
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial
   begin : main_seq
      pkt_entry_t e;
      void'($urandom(52));
      rst = 1'b1;
      apb_req = '0;
      hold_mask = '0;
      spur_go = 1'b0;
      spur_op = '0;
      spur_vc = '0;
      cyc = 0;
      for (int i = 0; i < np; i++)
      begin
         channel_in_ip[i] = '0;
         flow_ctrl_in_op[i] = '0;
         sending[i] = 1'b0;
         for (int v = 0; v < nv; v++)
         begin
            ucred[i][v] = buffer_depth;
            pending[i][v] = 0;
            held_recv[i][v] = 0;
            lock_src[i][v] = 0;
            busy[i][v] = 1'b0;
         end
      end
      repeat (10) tick();
      rst = 1'b0;

      check_val("error", 0, error);
      apb_read_check(vcr_pkg::reg_ctrl_addr, 0, 1'b0);
      apb_read_check(vcr_pkg::reg_err_status_addr, 0, 1'b0);
      apb_read_check(8'h08, 0, 1'b1);
      repeat (5) tick();

      for (int n = 0; n < num_entries; n++)
      begin
         e = pkt_table[n];
         @(negedge clk);
         hold_mask = hold_mask | e.hold;
         gap_q[e.src].push_back($urandom % 4);
         pq[e.src].push_back(e);
         if (e.last)
            run_group(e);
      end

      check_val("error", 0, error);
      apb_read_check(vcr_pkg::reg_err_status_addr, 0, 1'b0);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- list.f
+incdir+bench
hdl/vcr_pkg.sv
hdl/vcr_input_port.sv
hdl/vcr_sw_alloc.sv
hdl/vcr_output_port.sv
hdl/vcr_err_cfg.sv
hdl/vcr_top.sv
bench/vcr_tb.sv
